//--- Makefile
VERILATOR  := verilator
TOP        := apb_timer_tb
RTL_TOP    := apb_timer_top
FILELIST   := apb_timer.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := All tests passed

SOURCES := $(wildcard include/*.svh verilog/*.sv verification/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- apb_timer.f
+incdir+include
verilog/bus_pkg.sv
verilog/timer_pkg.sv
verilog/iob_apb2iob.sv
verilog/timer_csr.sv
verilog/timer_core.sv
verilog/apb_timer_top.sv
verification/apb_timer_tb.sv

//--- include/apb_timer_settings.svh
/* Bus widths, register offsets and reset values of the APB timer
   Included by the packages and by any RTL file that needs a width or offset */

`ifndef APB_TIMER_SETTINGS_SVH
`define APB_TIMER_SETTINGS_SVH

// Bus geometry
`define APB_TIMER_ADDR_W 12
`define APB_TIMER_DATA_W 32
`define APB_TIMER_STRB_W (`APB_TIMER_DATA_W / 8)

// Register map, byte offsets
`define TIMER_CTRL_OFFS    12'h000
`define TIMER_LOAD_OFFS    12'h004
`define TIMER_COUNT_OFFS   12'h008
`define TIMER_STATUS_OFFS  12'h00C
`define TIMER_SCRATCH_OFFS 12'h010

// Reset values
`define TIMER_SCRATCH_RST 32'h0000_0000

`endif

//--- verification/apb_timer_tb.sv
/* Directed testbench for the APB countdown timer
   Drives APB transfers into the top level and checks latency, registers and interrupt */

`timescale 1ns/1ps
`include "apb_timer_settings.svh"

module apb_timer_tb
   import bus_pkg::*, timer_pkg::*;
();

   localparam int NUM_TESTS   = 5;
   localparam int READY_LIMIT = 16;  // Cycles an access may take before giving up

   logic      clk;
   logic      rst;
   apb_req_t  apb_req;
   apb_resp_t apb_resp;
   logic      irq;

   int error_count;
   int pass_count;
   int fail_count;
   int last_latency;  // Cycles from enable to ready

   apb_timer_top apb_timer_top_inst (
      .clk_i     (clk),
      .rst_i     (rst),
      .apb_req_i (apb_req),
      .apb_resp_o(apb_resp),
      .irq_o     (irq)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Watchdog with a generous budget per test
   initial begin
      repeat (NUM_TESTS * 2000) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * 2000);
      $display("Some tests failed");
      $finish;
   end

   task automatic next_cycle();
      @(posedge clk);
      #1;  // Drive and sample just after the edge
   endtask

   task automatic check_equal(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      assert (actual === expected) else begin
         $display("[ERROR] %s expected %h, got %h", name, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_range(input string name, input logic [31:0] actual,
                              input logic [31:0] hi);
      assert (actual >= 32'd1 && actual <= hi) else begin
         $display("[ERROR] %s expected 00000001..%h, got %h", name, hi, actual);
         error_count++;
      end
   endtask

   // Reference byte merge from a lane mask
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  strb);
      logic [31:0] mask;
      for (int i = 0; i < 4; i++) begin
         mask[8*i +: 8] = {8{strb[i]}};
      end
      return (old_val & ~mask) | (new_val & mask);
   endfunction

   // Setup phase then access phase until ready
   task automatic apb_access(input logic write, input logic [11:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb,
                             output logic [31:0] rdata);
      int cycles;
      apb_req = '{sel: 1'b1, enable: 1'b0, write: write, addr: addr,
                  wdata: wdata, wstrb: wstrb};
      next_cycle();
      apb_req.enable = 1'b1;
      next_cycle();
      cycles = 1;
      while (!apb_resp.ready && cycles < READY_LIMIT) begin
         next_cycle();
         cycles++;
      end
      assert (apb_resp.ready) else begin
         $display("APB access to address %h never returned ready", addr);
         error_count++;
      end
      rdata        = apb_resp.rdata;
      last_latency = cycles;
      apb_req      = '0;
   endtask

   task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      logic [31:0] unused_rdata;
      apb_access(1'b1, addr, data, strb, unused_rdata);
   endtask

   task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
      apb_access(1'b0, addr, 32'h0, 4'h0, data);
   endtask

   // Read STATUS until the expired bit shows and optionally range check COUNT
   task automatic poll_expired(input int max_polls, input logic check_count,
                               input logic [31:0] n);
      logic [31:0] status;
      logic [31:0] count;
      int          polls;
      status = '0;
      polls  = 0;
      while (!status[0] && polls < max_polls) begin
         apb_read(`TIMER_STATUS_OFFS, status);
         if (check_count) begin
            apb_read(`TIMER_COUNT_OFFS, count);
            check_range("COUNT", count, n);
         end
         polls++;
      end
      assert (status[0]) else begin
         $display("STATUS expired bit still clear after %0d polls", max_polls);
         error_count++;
      end
   endtask

   // Stop the timer and drop any stale expired flag
   task automatic quiesce_timer();
      apb_write(`TIMER_CTRL_OFFS, 32'h0, 4'hF);
      apb_write(`TIMER_STATUS_OFFS, 32'h1, 4'hF);
   endtask

   task automatic end_test(input string name, input int errors_before);
      if (error_count == errors_before) begin
         pass_count++;
         $display("PASS  %s", name);
      end else begin
         fail_count++;
         $display("FAIL  %s with %0d errors", name, error_count - errors_before);
      end
   endtask

   task automatic test_reset_latency();
      logic [31:0] rd;
      logic [31:0] wr;
      int          errors_before;
      errors_before = error_count;
      wr = $urandom;
      check_equal("apb_resp_o.ready", 32'(apb_resp.ready), 32'h0);
      check_equal("irq_o", 32'(irq), 32'h0);
      apb_read(`TIMER_SCRATCH_OFFS, rd);
      check_equal("SCRATCH", rd, `TIMER_SCRATCH_RST);
      check_equal("read latency", 32'(last_latency), 32'd3);
      apb_write(`TIMER_SCRATCH_OFFS, wr, 4'hF);
      check_equal("write latency", 32'(last_latency), 32'd2);
      apb_read(`TIMER_SCRATCH_OFFS, rd);
      check_equal("SCRATCH", rd, wr);
      check_equal("read latency", 32'(last_latency), 32'd3);
      end_test("reset_latency", errors_before);
   endtask

   task automatic test_scratch_strobes();
      logic [31:0] base;
      logic [31:0] data;
      logic [31:0] rd;
      logic [31:0] expected;
      logic [3:0]  strb;
      int          errors_before;
      errors_before = error_count;
      repeat (8) begin
         data = $urandom;
         apb_write(`TIMER_SCRATCH_OFFS, data, 4'hF);
         apb_read(`TIMER_SCRATCH_OFFS, rd);
         check_equal("SCRATCH", rd, data);
      end
      repeat (8) begin
         base = $urandom;
         data = $urandom;
         strb = 4'(($urandom % 14) + 1);  // Partial lanes only
         apb_write(`TIMER_SCRATCH_OFFS, base, 4'hF);
         apb_write(`TIMER_SCRATCH_OFFS, data, strb);
         expected = merge_bytes(base, data, strb);
         apb_read(`TIMER_SCRATCH_OFFS, rd);
         check_equal("SCRATCH", rd, expected);
      end
      apb_write(12'h030, $urandom, 4'hF);  // Hole in the map
      apb_read(12'h030, rd);
      check_equal("unmapped rdata", rd, 32'h0);
      apb_read(`TIMER_SCRATCH_OFFS, rd);
      check_equal("SCRATCH", rd, expected);
      end_test("scratch_strobes", errors_before);
   endtask

   task automatic test_one_shot();
      logic [31:0] n;
      logic [31:0] rd;
      int          errors_before;
      errors_before = error_count;
      n = 4 + ($urandom % 12);
      quiesce_timer();
      apb_write(`TIMER_LOAD_OFFS, n, 4'hF);
      apb_read(`TIMER_COUNT_OFFS, rd);
      check_equal("COUNT", rd, n);
      apb_write(`TIMER_CTRL_OFFS, 32'h1, 4'hF);
      poll_expired(int'(n) + 8, 1'b0, n);
      apb_read(`TIMER_COUNT_OFFS, rd);
      check_equal("COUNT", rd, 32'h0);
      apb_read(`TIMER_COUNT_OFFS, rd);
      check_equal("COUNT", rd, 32'h0);  // Parked at zero
      quiesce_timer();
      end_test("one_shot", errors_before);
   endtask

   task automatic test_auto_reload();
      logic [31:0] n;
      int          errors_before;
      errors_before = error_count;
      n = 8 + ($urandom % 8);
      quiesce_timer();
      apb_write(`TIMER_LOAD_OFFS, n, 4'hF);
      apb_write(`TIMER_CTRL_OFFS, 32'h3, 4'hF);  // Enable with reload
      poll_expired(int'(n) + 8, 1'b1, n);
      apb_write(`TIMER_STATUS_OFFS, 32'h1, 4'hF);
      poll_expired(int'(n) + 8, 1'b1, n);
      quiesce_timer();
      end_test("auto_reload", errors_before);
   endtask

   task automatic test_irq_clear();
      logic [31:0] n;
      logic [31:0] rd;
      int          errors_before;
      errors_before = error_count;
      n = 3 + ($urandom % 4);
      quiesce_timer();
      apb_write(`TIMER_LOAD_OFFS, n, 4'hF);
      apb_write(`TIMER_CTRL_OFFS, 32'h1, 4'hF);
      poll_expired(int'(n) + 8, 1'b0, n);
      repeat (3) next_cycle();
      check_equal("irq_o", 32'(irq), 32'h0);
      apb_write(`TIMER_CTRL_OFFS, 32'h4, 4'hF);  // Interrupt enable with the timer stopped
      repeat (2) next_cycle();
      check_equal("irq_o", 32'(irq), 32'h1);
      apb_write(`TIMER_STATUS_OFFS, 32'h0, 4'hF);
      apb_read(`TIMER_STATUS_OFFS, rd);
      check_equal("STATUS", rd, 32'h1);
      check_equal("irq_o", 32'(irq), 32'h1);
      apb_write(`TIMER_STATUS_OFFS, 32'h1, 4'hF);
      repeat (2) next_cycle();
      apb_read(`TIMER_STATUS_OFFS, rd);
      check_equal("STATUS", rd, 32'h0);
      check_equal("irq_o", 32'(irq), 32'h0);
      end_test("irq_clear", errors_before);
   endtask

   initial begin
      rst          = 1'b1;
      apb_req      = '0;
      error_count  = 0;
      pass_count   = 0;
      fail_count   = 0;
      last_latency = 0;
      void'($urandom(9954));
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      test_reset_latency();
      test_scratch_strobes();
      test_one_shot();
      test_auto_reload();
      test_irq_clear();
      $display("Tests passed: %0d, failed: %0d, errors: %0d",
               pass_count, fail_count, error_count);
      if (fail_count == 0 && error_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- verilog/apb_timer_top.sv
/* APB countdown timer peripheral
   APB bridge, register block and countdown core, with one level interrupt out */

`timescale 1ns/1ps

module apb_timer_top
   import bus_pkg::*, timer_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,
   input  apb_req_t  apb_req_i,
   output apb_resp_t apb_resp_o,
   output logic      irq_o
);

   iob_req_t    iob_req;
   iob_resp_t   iob_resp;
   timer_cfg_t  timer_cfg;
   timer_stat_t timer_stat;

   // APB to IOb conversion
   iob_apb2iob iob_apb2iob_inst (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .apb_req_i (apb_req_i),
      .apb_resp_o(apb_resp_o),
      .iob_req_o (iob_req),
      .iob_resp_i(iob_resp)
   );

   timer_csr timer_csr_inst (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .iob_req_i (iob_req),
      .iob_resp_o(iob_resp),
      .cfg_o     (timer_cfg),
      .stat_i    (timer_stat),
      .irq_o     (irq_o)   // Registered in the CSR
   );

   timer_core timer_core_inst (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .cfg_i (timer_cfg),
      .stat_o(timer_stat)
   );

endmodule

//--- verilog/bus_pkg.sv
/* Bus payload types for the APB subordinate port and the internal IOb link
   Imported by the bridge, the register block and the top level */

`include "apb_timer_settings.svh"

package bus_pkg;

   typedef struct packed {
      logic                         sel;
      logic                         enable;
      logic                         write;
      logic [`APB_TIMER_ADDR_W-1:0] addr;
      logic [`APB_TIMER_DATA_W-1:0] wdata;
      logic [`APB_TIMER_STRB_W-1:0] wstrb;
   } apb_req_t;

   typedef struct packed {
      logic                         ready;
      logic [`APB_TIMER_DATA_W-1:0] rdata;
   } apb_resp_t;

   typedef struct packed {
      logic                         valid;
      logic [`APB_TIMER_ADDR_W-1:0] addr;
      logic [`APB_TIMER_DATA_W-1:0] wdata;
      logic [`APB_TIMER_STRB_W-1:0] wstrb;  // All zero marks a read
      logic                         rready;
   } iob_req_t;

   typedef struct packed {
      logic                         ready;
      logic                         rvalid;
      logic [`APB_TIMER_DATA_W-1:0] rdata;
   } iob_resp_t;

   typedef enum logic [1:0] {
      IDLE      = 2'd0,
      REQUEST   = 2'd1,
      READ_WAIT = 2'd2,
      DONE      = 2'd3
   } bridge_state_t;

endpackage

//--- verilog/iob_apb2iob.sv
/* APB subordinate to IOb manager bridge
   Each APB transfer becomes exactly one IOb access, with a registered APB ready */

`timescale 1ns/1ps

module iob_apb2iob
   import bus_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,
   input  apb_req_t  apb_req_i,
   output apb_resp_t apb_resp_o,
   output iob_req_t  iob_req_o,
   input  iob_resp_t iob_resp_i
);

   bridge_state_t                state_q;
   bridge_state_t                state_nxt;
   logic                         apb_ready_q;
   logic                         apb_ready_nxt;
   logic [$bits(apb_resp_o.rdata)-1:0] apb_rdata_q;
   logic                         iob_valid;
   logic                         iob_rready;
   logic                         rdata_en;

   assign iob_valid  = (state_q == REQUEST);  // Never in IDLE, see each access once
   assign iob_rready = (state_q == READ_WAIT);
   assign rdata_en   = iob_resp_i.rvalid & iob_rready;

   // Address and data pass straight through
   assign iob_req_o = '{
      valid:  iob_valid,
      addr:   apb_req_i.addr,
      wdata:  apb_req_i.wdata,
      wstrb:  apb_req_i.write ? apb_req_i.wstrb : '0,
      rready: iob_rready
   };

   assign apb_resp_o = '{ready: apb_ready_q, rdata: apb_rdata_q};

   always_comb begin
      state_nxt     = state_q;
      apb_ready_nxt = 1'b0;

      case (state_q)
         IDLE: begin
            if (apb_req_i.sel && apb_req_i.enable) begin
               state_nxt = REQUEST;
            end
         end
         REQUEST: begin
            // Hold valid until the subordinate takes it
            if (iob_resp_i.ready) begin
               if (apb_req_i.write) begin
                  state_nxt     = DONE;
                  apb_ready_nxt = 1'b1;
               end else begin
                  state_nxt = READ_WAIT;
               end
            end
         end
         READ_WAIT: begin
            if (iob_resp_i.rvalid) begin
               state_nxt     = DONE;
               apb_ready_nxt = 1'b1;
            end
         end
         default: begin  // DONE
            state_nxt = IDLE;  // One cycle gap so a lingering enable is ignored
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q     <= IDLE;
         apb_ready_q <= 1'b0;
      end else begin
         state_q     <= state_nxt;
         apb_ready_q <= apb_ready_nxt;
      end
   end

   // Read data held for the APB access phase
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         apb_rdata_q <= '0;
      end else if (rdata_en) begin
         apb_rdata_q <= iob_resp_i.rdata;
      end
   end

endmodule

//--- verilog/timer_core.sv
/* Countdown core of the timer
   Loads on strobe, counts down while enabled and pulses expire on the last tick */

`timescale 1ns/1ps
`include "apb_timer_settings.svh"

module timer_core
   import timer_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  timer_cfg_t  cfg_i,
   output timer_stat_t stat_o
);

   logic [`APB_TIMER_DATA_W-1:0] count_q;
   logic [`APB_TIMER_DATA_W-1:0] count_nxt;
   logic                         last_tick;
   logic                         expire;

   assign last_tick = (count_q == `APB_TIMER_DATA_W'(1));
   assign expire    = cfg_i.enable & last_tick & ~cfg_i.load_strobe;  // Load takes priority

   always_comb begin
      count_nxt = count_q;
      if (cfg_i.load_strobe) begin
         count_nxt = cfg_i.load_value;
      end else if (cfg_i.enable && (count_q != '0)) begin
         if (last_tick) begin
            // Reload or park at zero until the next load
            count_nxt = cfg_i.auto_reload ? cfg_i.load_value : '0;
         end else begin
            count_nxt = count_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         count_q <= '0;
      end else begin
         count_q <= count_nxt;
      end
   end

   assign stat_o = '{count: count_q, expire: expire};

endmodule

//--- verilog/timer_csr.sv
/* Timer register block on the IOb subordinate side
   Holds CTRL, LOAD, SCRATCH and the sticky expired flag, drives the core and the IRQ */

`timescale 1ns/1ps
`include "apb_timer_settings.svh"

module timer_csr
   import bus_pkg::*, timer_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  iob_req_t    iob_req_i,
   output iob_resp_t   iob_resp_o,
   output timer_cfg_t  cfg_o,
   input  timer_stat_t stat_i,
   output logic        irq_o
);

   // Byte lane merge of a write into an existing value
   function automatic logic [`APB_TIMER_DATA_W-1:0] apply_strb(
      input logic [`APB_TIMER_DATA_W-1:0] old_val,
      input logic [`APB_TIMER_DATA_W-1:0] new_val,
      input logic [`APB_TIMER_STRB_W-1:0] strb
   );
      logic [`APB_TIMER_DATA_W-1:0] res;
      res = old_val;
      for (int i = 0; i < `APB_TIMER_STRB_W; i++) begin
         if (strb[i]) begin
            res[8*i +: 8] = new_val[8*i +: 8];
         end
      end
      return res;
   endfunction

   timer_reg_t                   reg_sel;
   logic                         wr_en;
   logic                         rd_en;
   logic                         ctrl_wr;
   logic                         load_wr;
   logic                         status_clr;
   logic                         scratch_wr;
   logic [`APB_TIMER_DATA_W-1:0] load_nxt;
   logic [`APB_TIMER_DATA_W-1:0] rdata_nxt;

   logic                         enable_q;
   logic                         auto_reload_q;
   logic                         irq_en_q;
   logic [`APB_TIMER_DATA_W-1:0] load_q;
   logic [`APB_TIMER_DATA_W-1:0] scratch_q;
   logic                         expired_q;
   logic                         rvalid_q;
   logic                         irq_q;
   logic [`APB_TIMER_DATA_W-1:0] rdata_q;

   // Ready is tied high, so valid alone means accepted
   assign wr_en   = iob_req_i.valid & (|iob_req_i.wstrb);
   assign rd_en   = iob_req_i.valid & ~(|iob_req_i.wstrb);
   assign reg_sel = timer_reg_t'(iob_req_i.addr);

   assign ctrl_wr    = wr_en && (reg_sel == REG_CTRL) && iob_req_i.wstrb[0];
   assign load_wr    = wr_en && (reg_sel == REG_LOAD);
   assign scratch_wr = wr_en && (reg_sel == REG_SCRATCH);
   assign status_clr = wr_en && (reg_sel == REG_STATUS) && iob_req_i.wstrb[0]
                       && iob_req_i.wdata[0];  // Write 1 to clear

   assign load_nxt = apply_strb(load_q, iob_req_i.wdata, iob_req_i.wstrb);

   // New LOAD value goes to the core in the same cycle as the write
   assign cfg_o = '{
      enable:      enable_q,
      auto_reload: auto_reload_q,
      load_strobe: load_wr,
      load_value:  load_wr ? load_nxt : load_q
   };

   assign iob_resp_o = '{ready: 1'b1, rvalid: rvalid_q, rdata: rdata_q};
   assign irq_o      = irq_q;

   always_comb begin
      rdata_nxt = '0;  // Unmapped reads return zero
      case (reg_sel)
         REG_CTRL:    rdata_nxt[2:0] = {irq_en_q, auto_reload_q, enable_q};
         REG_LOAD:    rdata_nxt      = load_q;
         REG_COUNT:   rdata_nxt      = stat_i.count;
         REG_STATUS:  rdata_nxt[0]   = expired_q;
         REG_SCRATCH: rdata_nxt      = scratch_q;
         default:     rdata_nxt      = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         enable_q      <= 1'b0;
         auto_reload_q <= 1'b0;
         irq_en_q      <= 1'b0;
         load_q        <= '0;
         scratch_q     <= `TIMER_SCRATCH_RST;
         expired_q     <= 1'b0;
         rvalid_q      <= 1'b0;
         irq_q         <= 1'b0;
      end else begin
         if (ctrl_wr) begin
            {irq_en_q, auto_reload_q, enable_q} <= iob_req_i.wdata[2:0];
         end
         if (load_wr) begin
            load_q <= load_nxt;
         end
         if (scratch_wr) begin
            scratch_q <= apply_strb(scratch_q, iob_req_i.wdata, iob_req_i.wstrb);
         end
         if (stat_i.expire) begin
            expired_q <= 1'b1;  // Set beats clear
         end else if (status_clr) begin
            expired_q <= 1'b0;
         end
         rvalid_q <= rd_en | (rvalid_q & ~iob_req_i.rready);
         irq_q    <= expired_q & irq_en_q;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_q <= rdata_nxt;
      end
   end

endmodule

//--- verilog/timer_pkg.sv
/* Timer register map and the configuration and status bundles
   exchanged between the register block and the countdown core */

`include "apb_timer_settings.svh"

package timer_pkg;

   // Register offsets as seen on the IOb address
   typedef enum logic [`APB_TIMER_ADDR_W-1:0] {
      REG_CTRL    = `TIMER_CTRL_OFFS,
      REG_LOAD    = `TIMER_LOAD_OFFS,
      REG_COUNT   = `TIMER_COUNT_OFFS,
      REG_STATUS  = `TIMER_STATUS_OFFS,
      REG_SCRATCH = `TIMER_SCRATCH_OFFS
   } timer_reg_t;

   typedef struct packed {
      logic                         enable;
      logic                         auto_reload;
      logic                         load_strobe;  // One cycle per LOAD write
      logic [`APB_TIMER_DATA_W-1:0] load_value;
   } timer_cfg_t;

   typedef struct packed {
      logic [`APB_TIMER_DATA_W-1:0] count;
      logic                         expire;       // Single cycle pulse
   } timer_stat_t;

endpackage
